// ==== Makefile ====
# Verilator build and run of the decode stage testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+logic
logic/decode_pkg.sv
logic/decode_reg_field.sv
logic/decode_imm.sv
logic/decode_class.sv
logic/decode_stage.sv
logic/stage_reg.sv
logic/decode_top.sv
bench/tb_clock.sv
bench/decode_tb.sv

// ==== bench/decode_tb.sv ====
// ==================================================
// Testbench of the decode top level. Drives random
// micro-ops, keeps its own expected decode bus and
// checks dbo against it with concurrent assertions
// sampled on the falling clock edge
// ==================================================

`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_tb;

	localparam int PERIOD_NS    = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS    = 3000;
	localparam int WATCHDOG_NS  = (NUM_TESTS * 2 + RESET_CYCLES) * PERIOD_NS;

	logic                    clk, rst, en;
	logic [31:0]             ip, instr_raw;
	decode_pkg::mode_t       om;
	decode_pkg::micro_op_t   instr;
	decode_pkg::decode_bus_t dbo, exp_bus;
	decode_pkg::pc_tag_t     dbo_tag, exp_tag;

	int err_reset = 0;
	int err_class = 0;
	int err_regs  = 0;
	int err_imm   = 0;
	int err_cause = 0;
	int err_tag   = 0;
	int err_hold  = 0;

	logic [31:0] rng_state = 32'h406f1d9e;

	decode_pkg::opcode_t known_ops [24] = '{
		decode_pkg::OP_ADD, decode_pkg::OP_ADDI, decode_pkg::OP_ADDL, decode_pkg::OP_AND,
		decode_pkg::OP_OR, decode_pkg::OP_XOR, decode_pkg::OP_MUL, decode_pkg::OP_MULU,
		decode_pkg::OP_DIV, decode_pkg::OP_DIVU, decode_pkg::OP_LOAD, decode_pkg::OP_LOADZ,
		decode_pkg::OP_STORE, decode_pkg::OP_BCC, decode_pkg::OP_BSR, decode_pkg::OP_JSR,
		decode_pkg::OP_RET, decode_pkg::OP_FENCE, decode_pkg::OP_CSR, decode_pkg::OP_SYS,
		decode_pkg::OP_BRK, decode_pkg::OP_NOP, decode_pkg::OP_FADD, decode_pkg::OP_FMA
	};

	tb_clock #(.PERIOD_NS(PERIOD_NS)) u_clock (.clk(clk));

	decode_top u_dut (
		.clk(clk), .rst(rst), .en(en), .ip(ip), .om(om), .instr(instr),
		.instr_raw(instr_raw), .dbo(dbo), .dbo_tag(dbo_tag)
	);

	// ==================================================
	// Random source and stimulus helpers
	// ==================================================

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic is_known(input logic [6:0] code);
		logic hit;
		hit = 1'b0;
		foreach (known_ops[i])
			if (known_ops[i] == code)
				hit = 1'b1;
		return hit;
	endfunction

	// Register zero, the ip register and the privileged range come up often
	function automatic logic [`DEC_REG_BITS-1:0] pick_reg(input logic [31:0] r);
		case (r[1:0])
			2'd0:    return '0;
			2'd1:    return `DEC_REG_BITS'(`DEC_IP_REG);
			2'd2:    return `DEC_REG_BITS'(`DEC_PRIV_BASE) + {3'd0, r[4:2]};
			default: return r[7:2];
		endcase
	endfunction

	task automatic drive_random();
		decode_pkg::micro_op_t u;
		logic [31:0]           r;
		logic [6:0]            code;
		int                    idx;
		r = next_rand();
		u.v = (r[2:0] != 3'd0);
		// Four in five opcodes come from the known set
		if ((r[31:8] % 24'd5) != 24'd0) begin
			// A fresh draw keeps the opcode independent of the valid bit
			idx = int'(next_rand() % 32'd24);
			u.opcode = known_ops[idx];
		end else begin
			code = r[14:8];
			while (is_known(code))
				code = code + 7'd1;
			u.opcode = decode_pkg::opcode_t'(code);
		end
		u.rd = pick_reg(next_rand());
		u.rs1 = pick_reg(next_rand());
		u.rs2 = pick_reg(next_rand());
		r = next_rand();
		// An all ones func turns a fence into a sync
		u.func = (r[3:0] == 4'd0) ? `DEC_SYNC_FUNC : {r[4], pick_reg(r >> 5)};
		instr <= u;
		om <= decode_pkg::mode_t'(r[20]);
		en <= (r[22:21] != 2'b00);
		ip <= next_rand();
		instr_raw <= next_rand();
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	// The reset image is a plain nop with nothing valid
	function automatic decode_pkg::decode_bus_t expected_idle();
		decode_pkg::decode_bus_t b;
		b = '0;
		b.flags.nop = 1'b1;
		b.cause = decode_pkg::FLT_NONE;
		return b;
	endfunction

	function automatic logic is_priv(input logic [`DEC_REG_BITS-1:0] n);
		return n >= `DEC_REG_BITS'(`DEC_PRIV_BASE);
	endfunction

	function automatic decode_pkg::decode_bus_t model_decode(
		input decode_pkg::micro_op_t u,
		input decode_pkg::mode_t     m,
		input logic [31:0]           raw
	);
		decode_pkg::decode_bus_t  b;
		logic                     known;
		logic                     bad;
		logic [`DEC_IMM_BITS-1:0] s;
		b = expected_idle();
		if (!u.v)
			return b;
		b.v = 1'b1;
		b.flags.nop = 1'b0;
		known = 1'b1;
		case (u.opcode)
			decode_pkg::OP_ADD, decode_pkg::OP_ADDI, decode_pkg::OP_ADDL,
			decode_pkg::OP_AND, decode_pkg::OP_OR, decode_pkg::OP_XOR: b.flags.alu = 1'b1;
			decode_pkg::OP_MUL:   b.flags.mul = 1'b1;
			decode_pkg::OP_MULU:  b.flags.mulu = 1'b1;
			decode_pkg::OP_DIV:   b.flags.div = 1'b1;
			decode_pkg::OP_DIVU:  b.flags.divu = 1'b1;
			decode_pkg::OP_LOAD:  b.flags.load = 1'b1;
			decode_pkg::OP_LOADZ: b.flags.loadz = 1'b1;
			decode_pkg::OP_STORE: b.flags.store = 1'b1;
			decode_pkg::OP_BCC:   b.flags.branch = 1'b1;
			decode_pkg::OP_BSR:   b.flags.bsr = 1'b1;
			decode_pkg::OP_JSR:   b.flags.jsr = 1'b1;
			decode_pkg::OP_RET:   b.flags.ret = 1'b1;
			decode_pkg::OP_FENCE: b.flags.fence = 1'b1;
			decode_pkg::OP_CSR:   b.flags.csr = 1'b1;
			decode_pkg::OP_SYS:   b.flags.sys = 1'b1;
			decode_pkg::OP_BRK:   b.flags.brk = 1'b1;
			decode_pkg::OP_NOP:   b.flags.nop = 1'b1;
			decode_pkg::OP_FADD:  b.flags.fpu = 1'b1;
			decode_pkg::OP_FMA:   b.flags.fma = 1'b1;
			default:              known = 1'b0;
		endcase
		b.flags.mem = b.flags.load | b.flags.loadz | b.flags.store;
		b.flags.sync = b.flags.fence & (u.func == `DEC_SYNC_FUNC);
		b.rd = u.rd;
		b.rs1 = u.rs1;
		b.rs2 = u.rs2;
		b.rs3 = u.func[`DEC_REG_BITS-1:0];
		b.rs1z = (u.rs1 == '0);
		b.rs2z = (u.rs2 == '0);
		b.iprel = (u.rs1 == `DEC_REG_BITS'(`DEC_IP_REG));
		// Short immediate is rs2 on top of func and is sign extended
		s = {u.rs2, u.func};
		if (u.opcode inside {decode_pkg::OP_ADDI, decode_pkg::OP_LOAD, decode_pkg::OP_LOADZ,
			decode_pkg::OP_STORE, decode_pkg::OP_BCC}) begin
			b.has_imm = 1'b1;
			b.imm = {{(64 - `DEC_IMM_BITS){s[`DEC_IMM_BITS-1]}}, s};
		end else if (u.opcode == decode_pkg::OP_ADDL) begin
			b.has_imm = 1'b1;
			b.imm = {{32{raw[31]}}, raw};
		end
		b.has_rs2 = !b.has_imm;
		b.rdv = !(u.opcode inside {decode_pkg::OP_STORE, decode_pkg::OP_BCC,
			decode_pkg::OP_FENCE, decode_pkg::OP_BRK, decode_pkg::OP_SYS, decode_pkg::OP_NOP});
		// Only operands the micro-op really reads or writes can fault
		bad = is_priv(u.rs1) | (is_priv(u.rs2) & b.has_rs2) | (is_priv(u.rd) & b.rdv) |
			(is_priv(b.rs3) & (u.opcode == decode_pkg::OP_FMA));
		if (!known)
			b.cause = decode_pkg::FLT_UNIMP;
		else if (bad && m == decode_pkg::MODE_USER)
			b.cause = decode_pkg::FLT_BADREG;
		else
			b.cause = decode_pkg::FLT_NONE;
		return b;
	endfunction

	// Expected registers follow the same load and hold rule as the DUT
	always @(posedge clk) begin
		if (rst) begin
			exp_bus <= expected_idle();
			exp_tag <= '0;
		end else if (en) begin
			exp_bus <= model_decode(instr, om, instr_raw);
			exp_tag <= {ip, om};
		end
	end

	// ==================================================
	// Checks sampled mid cycle where outputs are stable
	// ==================================================

	reset_image: assert property (@(negedge clk) rst |=> (dbo == expected_idle() &&
		dbo_tag == '0))
	else begin
		err_reset++;
		$display("Error reset_image: expected %0h actual %0h", expected_idle(), dbo);
	end

	class_flags: assert property (@(negedge clk) (dbo.v == exp_bus.v &&
		dbo.flags == exp_bus.flags))
	else begin
		err_class++;
		$display("Error class_flags: expected %0h actual %0h",
			{exp_bus.v, exp_bus.flags}, {dbo.v, dbo.flags});
	end

	reg_fields: assert property (@(negedge clk)
		{dbo.rd, dbo.rs1, dbo.rs2, dbo.rs3, dbo.rdv, dbo.rs1z, dbo.rs2z, dbo.iprel} ==
		{exp_bus.rd, exp_bus.rs1, exp_bus.rs2, exp_bus.rs3, exp_bus.rdv, exp_bus.rs1z,
			exp_bus.rs2z, exp_bus.iprel})
	else begin
		err_regs++;
		$display("Error reg_fields: expected %0h actual %0h", exp_bus, dbo);
	end

	immediate: assert property (@(negedge clk) (dbo.imm == exp_bus.imm &&
		dbo.has_imm == exp_bus.has_imm && dbo.has_rs2 == exp_bus.has_rs2))
	else begin
		err_imm++;
		$display("Error immediate: expected %0h actual %0h",
			{exp_bus.has_imm, exp_bus.has_rs2, exp_bus.imm}, {dbo.has_imm, dbo.has_rs2, dbo.imm});
	end

	fault_cause: assert property (@(negedge clk) dbo.cause == exp_bus.cause)
	else begin
		err_cause++;
		$display("Error fault_cause: expected %0h actual %0h", exp_bus.cause, dbo.cause);
	end

	pc_tag: assert property (@(negedge clk) dbo_tag == exp_tag)
	else begin
		err_tag++;
		$display("Error pc_tag: expected %0h actual %0h", exp_tag, dbo_tag);
	end

	enable_hold: assert property (@(negedge clk) (!rst && !en) |=>
		($stable(dbo) && $stable(dbo_tag)))
	else begin
		err_hold++;
		$display("Outputs changed on a clock edge while en was low");
	end

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		int total;
		rst = 1'b1;
		en = 1'b0;
		ip = '0;
		om = decode_pkg::MODE_USER;
		instr = '0;
		instr_raw = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		// A few idle cycles show the reset image before any en
		repeat (2) @(posedge clk);
		for (int i = 0; i < NUM_TESTS; i++) begin
			@(posedge clk);
			drive_random();
		end
		@(posedge clk);
		en <= 1'b0;
		repeat (3) @(negedge clk);
		total = err_reset + err_class + err_regs + err_imm + err_cause + err_tag + err_hold;
		$display("Errors: reset=%0d class=%0d regs=%0d imm=%0d cause=%0d tag=%0d hold=%0d",
			err_reset, err_class, err_regs, err_imm, err_cause, err_tag, err_hold);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the test sequence finished");
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== bench/tb_clock.sv ====
// ==================================================
// Free running testbench clock, low at time zero
// ==================================================

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

// ==== logic/decode_class.sv ====
// ==================================================
// Opcode classifier. Sets one primary class flag per
// known opcode, derives mem and sync, and reports
// whether the opcode is implemented at all
// ==================================================

`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_class (
	input  decode_pkg::micro_op_t    instr,
	output decode_pkg::class_flags_t flags,
	output logic                     known
);

	logic [18:0] primary;

	always_comb begin
		flags = '0;
		known = 1'b1;
		case (instr.opcode)
			// Plain integer operations share one unit
			decode_pkg::OP_ADD,
			decode_pkg::OP_ADDI,
			decode_pkg::OP_ADDL,
			decode_pkg::OP_AND,
			decode_pkg::OP_OR,
			decode_pkg::OP_XOR:   flags.alu = 1'b1;
			decode_pkg::OP_MUL:   flags.mul = 1'b1;
			decode_pkg::OP_MULU:  flags.mulu = 1'b1;
			decode_pkg::OP_DIV:   flags.div = 1'b1;
			decode_pkg::OP_DIVU:  flags.divu = 1'b1;
			decode_pkg::OP_LOAD:  flags.load = 1'b1;
			decode_pkg::OP_LOADZ: flags.loadz = 1'b1;
			decode_pkg::OP_STORE: flags.store = 1'b1;
			decode_pkg::OP_BCC:   flags.branch = 1'b1;
			decode_pkg::OP_BSR:   flags.bsr = 1'b1;
			decode_pkg::OP_JSR:   flags.jsr = 1'b1;
			decode_pkg::OP_RET:   flags.ret = 1'b1;
			decode_pkg::OP_FENCE: flags.fence = 1'b1;
			decode_pkg::OP_CSR:   flags.csr = 1'b1;
			decode_pkg::OP_SYS:   flags.sys = 1'b1;
			decode_pkg::OP_BRK:   flags.brk = 1'b1;
			decode_pkg::OP_NOP:   flags.nop = 1'b1;
			decode_pkg::OP_FADD:  flags.fpu = 1'b1;
			decode_pkg::OP_FMA:   flags.fma = 1'b1;
			// Unknown code, no class at all
			default:              known = 1'b0;
		endcase

		// Derived flags go on top of the primary one
		flags.mem = flags.load | flags.loadz | flags.store;
		flags.sync = flags.fence && (instr.func == `DEC_SYNC_FUNC);
	end

	// Primary flags only, mem and sync overlap by design
	assign primary = {
		flags.alu, flags.mul, flags.mulu, flags.div, flags.divu,
		flags.load, flags.loadz, flags.store, flags.branch, flags.bsr,
		flags.jsr, flags.ret, flags.fence, flags.csr, flags.sys,
		flags.brk, flags.fpu, flags.fma, flags.nop
	};

	// At most one class, and a class exactly when the opcode is known
	always_comb begin
		assert ($onehot0(primary) && (known == (primary != '0)))
		else $error("decode_class: bad class flags %b for opcode %h",
			primary, instr.opcode);
	end

endmodule

// ==== logic/decode_consts.svh ====
// ==================================================
// Numeric constants of the decode stage.
// Include this header where register widths,
// the privileged range or immediate sizes are needed
// ==================================================

`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Width of one register specifier in the micro-op
`define DEC_REG_BITS 6

// First register of the privileged range, up to the top of the file
`define DEC_PRIV_BASE 56

// This register reads as the instruction pointer
`define DEC_IP_REG 62

// A fence whose function field is all ones acts as a sync
`define DEC_SYNC_FUNC 7'h7F

// Short immediate, built from the rs2 and func fields
`define DEC_IMM_BITS 13

`endif

// ==== logic/decode_imm.sv ====
// ==================================================
// Immediate decoder. Short immediates come from the
// rs2 and func fields and are sign extended, while
// ADDL takes a full constant from the raw word
// ==================================================

`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_imm (
	input  decode_pkg::micro_op_t instr,
	input  logic [31:0]           instr_raw,
	output logic [63:0]           imm,
	output logic                  has_imm
);

	logic [`DEC_IMM_BITS-1:0] short_imm;

	// rs2 forms the upper bits and func the lower bits
	assign short_imm = {instr.rs2, instr.func};

	always_comb begin
		imm = 64'd0;
		has_imm = 1'b0;
		case (instr.opcode)
			// Register plus offset forms and the branch displacement
			decode_pkg::OP_ADDI,
			decode_pkg::OP_LOAD,
			decode_pkg::OP_LOADZ,
			decode_pkg::OP_STORE,
			decode_pkg::OP_BCC: begin
				imm = 64'($signed(short_imm));
				has_imm = 1'b1;
			end
			// Long constant carried in the extension word
			decode_pkg::OP_ADDL: begin
				imm = 64'($signed(instr_raw));
				has_imm = 1'b1;
			end
			// Everything else uses registers only
			default: begin
				imm = 64'd0;
				has_imm = 1'b0;
			end
		endcase
	end

endmodule

// ==== logic/decode_pkg.sv ====
// ==================================================
// Shared types of the decode stage: opcodes, faults,
// operating modes, the micro-op and the decode bus.
// Reference types by scoped name from this package
// ==================================================

`include "decode_consts.svh"

package decode_pkg;

	// Known opcodes, every code not listed here is unimplemented
	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h01,
		OP_ADDI  = 7'h02,
		OP_ADDL  = 7'h03,
		OP_AND   = 7'h04,
		OP_OR    = 7'h05,
		OP_XOR   = 7'h06,
		OP_MUL   = 7'h08,
		OP_MULU  = 7'h09,
		OP_DIV   = 7'h0A,
		OP_DIVU  = 7'h0B,
		OP_LOAD  = 7'h10,
		OP_LOADZ = 7'h11,
		OP_STORE = 7'h12,
		OP_BCC   = 7'h18,
		OP_BSR   = 7'h19,
		OP_JSR   = 7'h1A,
		OP_RET   = 7'h1B,
		OP_FENCE = 7'h20,
		OP_CSR   = 7'h21,
		OP_SYS   = 7'h22,
		OP_BRK   = 7'h23,
		OP_FADD  = 7'h30,
		OP_FMA   = 7'h31
	} opcode_t;

	// Fault cause reported on the decode bus
	typedef enum logic [1:0] {
		FLT_NONE   = 2'd0,
		FLT_BADREG = 2'd1,
		FLT_UNIMP  = 2'd2
	} fault_t;

	typedef enum logic {
		MODE_USER    = 1'b0,
		MODE_MACHINE = 1'b1
	} mode_t;

	// Which micro-op field a register decoder reads
	typedef enum logic [1:0] {
		FLD_RD  = 2'd0,
		FLD_RS1 = 2'd1,
		FLD_RS2 = 2'd2,
		FLD_RS3 = 2'd3
	} field_sel_t;

	typedef struct packed {
		logic                     v;
		opcode_t                  opcode;
		logic [`DEC_REG_BITS-1:0] rd;
		logic [`DEC_REG_BITS-1:0] rs1;
		logic [`DEC_REG_BITS-1:0] rs2;
		logic [6:0]               func;
	} micro_op_t;

	// Class flags, mem and sync are derived from the others
	typedef struct packed {
		logic alu, mul, mulu, div, divu;
		logic load, loadz, store, mem;
		logic branch, bsr, jsr, ret;
		logic fence, sync, csr, sys, brk;
		logic fpu, fma, nop;
	} class_flags_t;

	typedef struct packed {
		logic                     v;
		logic [`DEC_REG_BITS-1:0] rd, rs1, rs2, rs3;
		logic                     rdv, rs1z, rs2z, has_rs2, iprel;
		logic [63:0]              imm;
		logic                     has_imm;
		class_flags_t             flags;
		fault_t                   cause;
	} decode_bus_t;

	typedef struct packed {
		logic [31:0] ip;
		mode_t       mode;
	} pc_tag_t;

	// Idle bus image, a plain nop without fault
	function automatic decode_bus_t idle_bus();
		decode_bus_t b;
		b = '0;
		b.flags.nop = 1'b1;
		b.cause = FLT_NONE;
		return b;
	endfunction

endpackage

// ==== logic/decode_reg_field.sv ====
// ==================================================
// Decodes one register specifier of a micro-op.
// FIELD picks rd, rs1, rs2 or the low func bits.
// Flags register zero, the ip register and use of
// a privileged register from user mode
// ==================================================

`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_reg_field #(
	parameter decode_pkg::field_sel_t FIELD = decode_pkg::FLD_RD
) (
	input  decode_pkg::micro_op_t     instr,
	input  decode_pkg::mode_t         om,
	output logic [`DEC_REG_BITS-1:0]  num,
	output logic                      zero,
	output logic                      ipref,
	output logic                      bad
);

	// Field select is fixed per instance
	always_comb begin
		case (FIELD)
			decode_pkg::FLD_RD:  num = instr.rd;
			decode_pkg::FLD_RS1: num = instr.rs1;
			decode_pkg::FLD_RS2: num = instr.rs2;
			// The third source sits in the low bits of func
			default:             num = instr.func[`DEC_REG_BITS-1:0];
		endcase
	end

	assign zero  = (num == '0);
	assign ipref = (num == `DEC_REG_BITS'(`DEC_IP_REG));

	// Registers 56 and up belong to machine mode
	// Touching them from user mode faults, machine mode may use them freely
	assign bad = (om == decode_pkg::MODE_USER) &&
		(num >= `DEC_REG_BITS'(`DEC_PRIV_BASE));

endmodule

// ==== logic/decode_stage.sv ====
// ==================================================
// Combinational decode of one micro-op into the
// decode bus. Joins the field, immediate and class
// decoders and settles the fault cause
// ==================================================

`timescale 1ns/1ps

`include "decode_consts.svh"

module decode_stage (
	input  decode_pkg::micro_op_t   instr,
	input  decode_pkg::mode_t       om,
	input  logic [31:0]             instr_raw,
	output decode_pkg::decode_bus_t db
);

	logic [`DEC_REG_BITS-1:0] rd_num, rs1_num, rs2_num, rs3_num;
	logic                     rs1_zero, rs2_zero, rs1_ip;
	logic                     rd_bad, rs1_bad, rs2_bad, rs3_bad;
	logic [63:0]              imm;
	logic                     has_imm, known, rdv, bad_any;
	decode_pkg::class_flags_t flags;

	// ==================================================
	// Field decoders
	// ==================================================

	decode_reg_field #(.FIELD(decode_pkg::FLD_RD)) u_rd (
		.instr(instr), .om(om), .num(rd_num), .zero(), .ipref(), .bad(rd_bad)
	);

	decode_reg_field #(.FIELD(decode_pkg::FLD_RS1)) u_rs1 (
		.instr(instr), .om(om), .num(rs1_num), .zero(rs1_zero), .ipref(rs1_ip),
		.bad(rs1_bad)
	);

	decode_reg_field #(.FIELD(decode_pkg::FLD_RS2)) u_rs2 (
		.instr(instr), .om(om), .num(rs2_num), .zero(rs2_zero), .ipref(),
		.bad(rs2_bad)
	);

	decode_reg_field #(.FIELD(decode_pkg::FLD_RS3)) u_rs3 (
		.instr(instr), .om(om), .num(rs3_num), .zero(), .ipref(), .bad(rs3_bad)
	);

	decode_imm u_imm (.instr(instr), .instr_raw(instr_raw), .imm(imm), .has_imm(has_imm));

	decode_class u_class (.instr(instr), .flags(flags), .known(known));

	// ==================================================
	// Operand rules and fault priority
	// ==================================================

	// These classes write no destination register
	assign rdv = ~(flags.store | flags.branch | flags.fence | flags.brk |
		flags.sys | flags.nop);

	// A bad flag only counts for an operand the micro-op really uses
	// The rs2 field holds immediate bits when has_imm is set
	assign bad_any = rs1_bad | (rs2_bad & ~has_imm) | (rd_bad & rdv) |
		(rs3_bad & flags.fma);

	always_comb begin
		db = '0;
		db.v = 1'b1;
		db.rd = rd_num;
		db.rs1 = rs1_num;
		db.rs2 = rs2_num;
		db.rs3 = rs3_num;
		db.rdv = rdv;
		db.rs1z = rs1_zero;
		db.rs2z = rs2_zero;
		db.has_rs2 = ~has_imm;
		db.iprel = rs1_ip;
		db.imm = imm;
		db.has_imm = has_imm;
		db.flags = flags;
		// Unimplemented wins over a bad register
		if (!known)
			db.cause = decode_pkg::FLT_UNIMP;
		else if (bad_any)
			db.cause = decode_pkg::FLT_BADREG;
		else
			db.cause = decode_pkg::FLT_NONE;
		// A stomped micro-op turns into a harmless nop
		if (!instr.v)
			db = decode_pkg::idle_bus();
	end

	// An invalid slot must never raise a fault or claim a destination
	always_comb begin
		if (!db.v)
			assert (db.cause == decode_pkg::FLT_NONE && db.flags.nop && !db.rdv)
			else $error("decode_stage: invalid micro-op left cause %s", db.cause.name());
	end

endmodule

// ==== logic/decode_top.sv ====
// ==================================================
// Decode stage top level. One micro-op per cycle in,
// a registered decode bus and ip tag out with one
// cycle of latency. en low holds both outputs
// ==================================================

`timescale 1ns/1ps

module decode_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    en,
	input  logic [31:0]             ip,
	input  decode_pkg::mode_t       om,
	input  decode_pkg::micro_op_t   instr,
	input  logic [31:0]             instr_raw,
	output decode_pkg::decode_bus_t dbo,
	output decode_pkg::pc_tag_t     dbo_tag
);

	decode_pkg::decode_bus_t db;
	decode_pkg::pc_tag_t     tag;

	// The tag travels next to the bus so rename sees the matching ip
	assign tag.ip = ip;
	assign tag.mode = om;

	decode_stage u_stage (.instr(instr), .om(om), .instr_raw(instr_raw), .db(db));

	stage_reg #(
		.T(decode_pkg::decode_bus_t),
		.RESET_VALUE(decode_pkg::idle_bus())
	) u_bus_reg (.clk(clk), .rst(rst), .en(en), .d(db), .q(dbo));

	stage_reg #(.T(decode_pkg::pc_tag_t), .RESET_VALUE('0)) u_tag_reg (
		.clk(clk), .rst(rst), .en(en), .d(tag), .q(dbo_tag)
	);

endmodule

// ==== logic/stage_reg.sv ====
// ==================================================
// Pipeline register for any packed payload type.
// Loads on a rising clock while en is high, holds
// otherwise, and takes RESET_VALUE under reset
// ==================================================

`timescale 1ns/1ps

module stage_reg #(
	parameter type T           = logic,
	parameter T    RESET_VALUE = '0
) (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  T     d,
	output T     q
);

	always_ff @(posedge clk) begin
		if (rst)
			q <= RESET_VALUE;
		else if (en)
			q <= d;
	end

	// en low is the only stall, the stage behind relies on a stable value
	hold_check: assert property (@(posedge clk) (!rst && !en) |=> (q == $past(q)))
	else $error("stage_reg: output changed while en was low");

endmodule
